// ==== hw/stm_param_pkg.sv ====
`default_nettype none

package stm_param_pkg;

  // Array geometry.
  localparam int num_trans = 8;                // Transducers driven per burst.
  localparam int trans_w = $clog2(num_trans);  // Transducer counter width.
  localparam int trans_pitch = 10;             // X spacing in position units.

  // Entry memory map.
  localparam int mem_words = 256;              // Entry words.
  localparam int mem_aw = 8;                   // Word address width.
  localparam int data_w = 32;                  // Wishbone data width.

  // Focus arithmetic.
  localparam int dist_sq_w = 18;               // Holds three 8-bit squares.
  localparam int dist_w = 9;
  localparam int phase_shift = 4;              // Scale of distance times wavenumber.

endpackage

`default_nettype wire

// ==== hw/stm_word_pkg.sv ====
`default_nettype none

package stm_word_pkg;

  // Gain view, one word per index and transducer.
  typedef struct packed {
    logic [15:0] rsvd;
    logic [7:0]  intensity;
    logic [7:0]  phase;
  } stm_gain_t;

  // Focus view, one focal point per index.
  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] z;            // Unsigned position units.
    logic [7:0] y;
    logic [7:0] x;
  } stm_focus_t;

  typedef union packed {
    stm_gain_t  gain;
    stm_focus_t focus;
  } stm_word_u;

endpackage

`default_nettype wire

// ==== hw/stm_bus_if.sv ====
`default_nettype none

interface stm_bus_if
  import stm_param_pkg::*, stm_word_pkg::*;
();

  logic [mem_aw-1:0] gain_addr;
  stm_word_u         gain_rdata;     // Valid one cycle after gain_addr.
  logic [mem_aw-1:0] focus_addr;
  stm_word_u         focus_rdata;    // Valid one cycle after focus_addr.

  modport memory_port(input gain_addr, input focus_addr, output gain_rdata, output focus_rdata);

  modport gain_port(output gain_addr, input gain_rdata);

  modport focus_port(output focus_addr, input focus_rdata);

endinterface

`default_nettype wire

// ==== hw/stm_memory.sv ====
`default_nettype none

module stm_memory
  import stm_param_pkg::*, stm_word_pkg::*;
(
  input  var logic              clk,
  input  var logic              rst_n,
  input  var logic              wb_cyc,
  input  var logic              wb_stb,
  input  var logic              wb_we,
  input  var logic [mem_aw-1:0] wb_adr,
  input  var logic [data_w-1:0] wb_dat_w,
  output var logic [data_w-1:0] wb_dat_r,
  output var logic              wb_ack,
  stm_bus_if.memory_port        bus
);

  stm_word_u mem[mem_words];
  logic      req;

  // A request is served once; the held stb during ack is not a second one.
  assign req = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;                 // Single-cycle ack, no wait state.
    end
  end

  // Host port.
  always_ff @(posedge clk) begin
    if (req && wb_we) begin
      mem[wb_adr] <= wb_dat_w;
    end
    if (req && !wb_we) begin
      wb_dat_r <= mem[wb_adr];       // Lands together with ack.
    end
  end

  // Operator read ports.
  always_ff @(posedge clk) begin
    bus.gain_rdata  <= mem[bus.gain_addr];
    bus.focus_rdata <= mem[bus.focus_addr];
  end

endmodule

`default_nettype wire

// ==== hw/stm_sampler.sv ====
`default_nettype none

module stm_sampler (
  input  var logic        clk,
  input  var logic        rst_n,
  input  var logic [63:0] sys_time,
  input  var logic [15:0] cycle_stm,
  input  var logic [31:0] freq_div_stm,
  output var logic [15:0] idx
);

  logic        mod_phase;    // Low for the divide step, high for the modulo step.
  logic [6:0]  iter;         // 64 means the current step has finished.
  logic        zero_div;
  logic [63:0] num;          // Dividend, shifted out as quotient bits shift in.
  logic [31:0] rem;
  logic [31:0] divisor;
  logic [33:0] diff;

  // Trial subtraction of one restoring iteration. Bit 33 is the borrow.
  assign diff = {1'b0, rem, num[63]} - {2'b00, divisor};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mod_phase <= 1'b1;       // Looks like a finished modulo step,
      iter      <= 7'd64;      // so the first edge latches sys_time.
      zero_div  <= 1'b1;
      idx       <= '0;
    end else if (iter != 7'd64) begin
      iter <= iter + 7'd1;
    end else if (!mod_phase) begin
      mod_phase <= 1'b1;
      iter      <= '0;
      zero_div  <= zero_div || (cycle_stm == '0);
    end else begin
      idx       <= zero_div ? '0 : rem[15:0];
      mod_phase <= 1'b0;
      iter      <= '0;
      zero_div  <= (freq_div_stm == '0);
    end
  end

  always_ff @(posedge clk) begin
    if (iter != 7'd64) begin
      rem <= diff[33] ? {rem[30:0], num[63]} : diff[31:0];
      num <= {num[62:0], ~diff[33]};
    end else if (!mod_phase) begin
      rem     <= '0;                  // Quotient stays in num as the new dividend.
      divisor <= {16'b0, cycle_stm};
    end else begin
      num     <= sys_time;
      rem     <= '0;
      divisor <= freq_div_stm;
    end
  end

endmodule

`default_nettype wire

// ==== hw/stm_gain_operator.sv ====
`default_nettype none

module stm_gain_operator
  import stm_param_pkg::*;
(
  input  var logic        clk,
  input  var logic        rst_n,
  input  var logic        update,
  input  var logic [15:0] idx,
  stm_bus_if.gain_port    bus,
  output var logic [7:0]  intensity,
  output var logic [7:0]  phase,
  output var logic        dout_valid
);

  logic [trans_w-1:0] cnt;
  logic               issuing;    // Addresses still going out.
  logic               rvalid;     // Read data on the bus belongs to the burst.
  logic               accept;

  // The burst owns the operator until its last beat has left.
  assign accept = update && !issuing && !rvalid && !dout_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issuing       <= 1'b0;
      cnt           <= '0;
      bus.gain_addr <= '0;
      rvalid        <= 1'b0;
      dout_valid    <= 1'b0;
    end else begin
      rvalid     <= issuing;
      dout_valid <= rvalid;
      if (accept) begin
        issuing       <= 1'b1;
        cnt           <= '0;
        bus.gain_addr <= mem_aw'(idx * num_trans);  // First word of this index.
      end else if (issuing) begin
        bus.gain_addr <= bus.gain_addr + 1'b1;
        cnt           <= cnt + 1'b1;
        if (int'(cnt) == num_trans - 1) begin
          issuing <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rvalid) begin
      intensity <= bus.gain_rdata.gain.intensity;
      phase     <= bus.gain_rdata.gain.phase;
    end
  end

endmodule

`default_nettype wire

// ==== hw/stm_isqrt.sv ====
`default_nettype none

module stm_isqrt
  import stm_param_pkg::*;
(
  input  var logic                 clk,
  input  var logic                 rst_n,
  input  var logic                 start,
  input  var logic [dist_sq_w-1:0] radicand,
  output var logic [dist_w-1:0]    root,
  output var logic                 done
);

  logic                      busy;
  logic [$clog2(dist_w)-1:0] cnt;
  logic [dist_sq_w-1:0]      rad;      // Radicand, two bits consumed per step.
  logic [dist_w+5:0]         rem;      // Signed partial remainder.
  logic [dist_w+5:0]         rem_sh;
  logic [dist_w+5:0]         rem_nx;

  // Non-restoring step: subtract 4q+1 after a positive remainder, else add 4q+3.
  always_comb begin
    rem_sh = {rem[dist_w+3:0], rad[dist_sq_w-1 -: 2]};
    if (rem[dist_w+5]) begin
      rem_nx = rem_sh + {4'b0000, root, 2'b11};
    end else begin
      rem_nx = rem_sh - {4'b0000, root, 2'b01};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt  <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start && !busy) begin
        busy <= 1'b1;
        cnt  <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (int'(cnt) == dist_w - 1) begin
          busy <= 1'b0;
          done <= 1'b1;                 // Root is final from here on.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start && !busy) begin
      rad  <= radicand;
      rem  <= '0;
      root <= '0;
    end else if (busy) begin
      rad  <= rad << 2;
      rem  <= rem_nx;
      root <= {root[dist_w-2:0], ~rem_nx[dist_w+5]};
    end
  end

endmodule

`default_nettype wire

// ==== hw/stm_focus_operator.sv ====
`default_nettype none

module stm_focus_operator
  import stm_param_pkg::*;
(
  input  var logic        clk,
  input  var logic        rst_n,
  input  var logic        update,
  input  var logic [15:0] idx,
  input  var logic [7:0]  wavenum,
  stm_bus_if.focus_port   bus,
  output var logic [7:0]  intensity,
  output var logic [7:0]  phase,
  output var logic        dout_valid
);

  enum logic [2:0] {s_idle, s_read, s_dist, s_root, s_scale} state;

  logic [trans_w-1:0]   t;             // Transducer in progress.
  logic [7:0]           wn;
  logic [7:0]           focal_int;
  logic [7:0]           tx;
  logic [7:0]           dx;
  logic [dist_sq_w-1:0] dx_e;
  logic [dist_sq_w-1:0] dy_e;
  logic [dist_sq_w-1:0] dz_e;
  logic [dist_sq_w-1:0] dist_sq;
  logic                 sqrt_start;
  logic                 sqrt_done;
  logic [dist_w-1:0]    root;
  logic [dist_w+7:0]    prod;
  logic [dist_w+7:0]    scaled;

  // Transducer t sits at (t * pitch, 0, 0).
  always_comb begin
    tx = 8'(t * trans_pitch);
    if (bus.focus_rdata.focus.x >= tx) begin
      dx = bus.focus_rdata.focus.x - tx;
    end else begin
      dx = tx - bus.focus_rdata.focus.x;
    end
    dx_e    = dist_sq_w'(dx);
    dy_e    = dist_sq_w'(bus.focus_rdata.focus.y);
    dz_e    = dist_sq_w'(bus.focus_rdata.focus.z);
    dist_sq = dx_e * dx_e + dy_e * dy_e + dz_e * dz_e;
  end

  assign sqrt_start = (state == s_dist);
  assign scaled     = prod >> phase_shift;

  stm_isqrt stm_isqrt (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (sqrt_start),
    .radicand(dist_sq),
    .root    (root),
    .done    (sqrt_done)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state          <= s_idle;
      t              <= '0;
      bus.focus_addr <= '0;
      dout_valid     <= 1'b0;
    end else begin
      dout_valid <= 1'b0;
      case (state)
        s_idle: begin
          if (update) begin
            state          <= s_read;
            t              <= '0;
            bus.focus_addr <= idx[mem_aw-1:0];  // One focal word per index.
          end
        end
        s_read:  state <= s_dist;     // Word read returns next cycle.
        s_dist:  state <= s_root;
        s_root: begin
          if (sqrt_done) begin
            state <= s_scale;
          end
        end
        s_scale: begin
          dout_valid <= 1'b1;
          t          <= t + 1'b1;
          state      <= (int'(t) == num_trans - 1) ? s_idle : s_read;
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_idle && update) begin
      wn <= wavenum;
    end
    if (state == s_dist) begin
      focal_int <= bus.focus_rdata.focus.intensity;
    end
    if (state == s_root && sqrt_done) begin
      prod <= root * wn;
    end
    if (state == s_scale) begin
      intensity <= focal_int;
      phase     <= scaled[7:0];     // Wraps modulo one period.
    end
  end

endmodule

`default_nettype wire

// ==== hw/stm_operator.sv ====
`default_nettype none

module stm_operator
  import stm_param_pkg::*;
(
  input  var logic              clk,
  input  var logic              rst_n,
  input  var logic [63:0]       sys_time,
  input  var logic              update,
  input  var logic [15:0]       cycle_stm,
  input  var logic [31:0]       freq_div_stm,
  input  var logic [7:0]        wavenum,
  input  var logic              gain_mode,
  input  var logic              wb_cyc,
  input  var logic              wb_stb,
  input  var logic              wb_we,
  input  var logic [mem_aw-1:0] wb_adr,
  input  var logic [data_w-1:0] wb_dat_w,
  output var logic [data_w-1:0] wb_dat_r,
  output var logic              wb_ack,
  output var logic [7:0]        intensity,
  output var logic [7:0]        phase,
  output var logic              dout_valid,
  output var logic [15:0]       idx
);

  stm_bus_if stm_bus ();

  logic [7:0] intensity_gain;
  logic [7:0] phase_gain;
  logic       dout_valid_gain;
  logic [7:0] intensity_focus;
  logic [7:0] phase_focus;
  logic       dout_valid_focus;
  logic       update_gain;
  logic       update_focus;

  // Only the selected operator sees the update pulse.
  assign update_gain  = update && gain_mode;
  assign update_focus = update && !gain_mode;

  assign intensity  = gain_mode ? intensity_gain : intensity_focus;
  assign phase      = gain_mode ? phase_gain : phase_focus;
  assign dout_valid = gain_mode ? dout_valid_gain : dout_valid_focus;

  stm_memory stm_memory (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r),
    .wb_ack  (wb_ack),
    .bus     (stm_bus.memory_port)
  );

  stm_sampler stm_sampler (
    .clk         (clk),
    .rst_n       (rst_n),
    .sys_time    (sys_time),
    .cycle_stm   (cycle_stm),
    .freq_div_stm(freq_div_stm),
    .idx         (idx)
  );

  stm_gain_operator stm_gain_operator (
    .clk       (clk),
    .rst_n     (rst_n),
    .update    (update_gain),
    .idx       (idx),
    .bus       (stm_bus.gain_port),
    .intensity (intensity_gain),
    .phase     (phase_gain),
    .dout_valid(dout_valid_gain)
  );

  stm_focus_operator stm_focus_operator (
    .clk       (clk),
    .rst_n     (rst_n),
    .update    (update_focus),
    .idx       (idx),
    .wavenum   (wavenum),
    .bus       (stm_bus.focus_port),
    .intensity (intensity_focus),
    .phase     (phase_focus),
    .dout_valid(dout_valid_focus)
  );

endmodule

`default_nettype wire

// ==== tb/stm_operator_assert.sv ====
`default_nettype none

module stm_operator_assert
  import stm_param_pkg::*;
(
  input var logic clk,
  input var logic rst_n,
  input var logic wb_cyc,
  input var logic wb_stb,
  input var logic wb_ack,
  input var logic gain_mode,
  input var logic dout_valid
);

  logic [7:0] run_len;       // Consecutive valid cycles so far.
  int         fail_cnt = 0;  // Failed assertions so far.

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_len <= '0;
    end else begin
      run_len <= dout_valid ? run_len + 8'd1 : 8'd0;
    end
  end

  ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
      $error("wb_ack without a request on the previous cycle");
      fail_cnt = fail_cnt + 1;
    end

  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack held for more than one cycle");
      fail_cnt = fail_cnt + 1;
    end

  valid_in_reset: assert property (@(posedge clk) !rst_n |-> !dout_valid)
    else begin
      $error("dout_valid high during reset");
      fail_cnt = fail_cnt + 1;
    end

  gain_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
    gain_mode && $fell(dout_valid) |-> int'(run_len) == num_trans)
    else begin
      $error("Gain burst length differs from the transducer count");
      fail_cnt = fail_cnt + 1;
    end

endmodule

`default_nettype wire

// ==== tb/stm_operator_tb.sv ====
`default_nettype none

module stm_operator_tb
  import stm_param_pkg::*, stm_word_pkg::*;
();

  // The tests take about 4200 cycles.
  localparam int cycle_limit = 20000;

  logic              clk;
  logic              rst_n;
  logic [63:0]       sys_time;
  logic              update;
  logic [15:0]       cycle_stm;
  logic [31:0]       freq_div_stm;
  logic [7:0]        wavenum;
  logic              gain_mode;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic [mem_aw-1:0] wb_adr;
  logic [data_w-1:0] wb_dat_w;
  logic [data_w-1:0] wb_dat_r;
  logic              wb_ack;
  logic [7:0]        intensity;
  logic [7:0]        phase;
  logic              dout_valid;
  logic [15:0]       idx;

  stm_word_u   model_mem[mem_words];  // What the host wrote.
  integer      seed = 38;
  int          cycles = 0;
  int          trans_cnt = 0;         // Transducer of the next beat.
  int          beat_total = 0;
  string       test_name;
  logic        cur_gain;
  logic [15:0] cur_idx;
  logic [7:0]  cur_wn;

  stm_operator dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .sys_time    (sys_time),
    .update      (update),
    .cycle_stm   (cycle_stm),
    .freq_div_stm(freq_div_stm),
    .wavenum     (wavenum),
    .gain_mode   (gain_mode),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .intensity   (intensity),
    .phase       (phase),
    .dout_valid  (dout_valid),
    .idx         (idx)
  );

  bind stm_operator stm_operator_assert stm_operator_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_ack    (wb_ack),
    .gain_mode (gain_mode),
    .dout_valid(dout_valid)
  );

  always #2 clk = ~clk;

  task automatic report_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
    $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
    $display("Simulation failed");
    $fatal(1, "Value mismatch in %s", name);
  endtask

  task automatic report_failure(input string what);
    $display("Simulation failed");
    $fatal(1, "%s", what);
  endtask

  // Expected {intensity, phase} of one beat.
  function automatic logic [15:0] ref_beat(input logic gain, input logic [15:0] index,
                                           input int t, input logic [7:0] wn,
                                           input stm_word_u mem[mem_words]);
    stm_word_u w;
    int        dx;
    int        dist_sq;
    int        root;
    if (gain) begin
      w = mem[(int'(index) * num_trans + t) % mem_words];  // Word k is index k/8, trans k%8.
      return {w.gain.intensity, w.gain.phase};
    end
    w = mem[int'(index) % mem_words];
    dx = int'(w.focus.x) - t * trans_pitch;
    dist_sq = dx * dx + int'(w.focus.y) * int'(w.focus.y) + int'(w.focus.z) * int'(w.focus.z);
    root = 0;
    while ((root + 1) * (root + 1) <= dist_sq) begin
      root++;
    end
    return {w.focus.intensity, 8'((root * int'(wn)) >> phase_shift)};
  endfunction

  // Outputs are registered, so the falling edge sees settled beats.
  always @(negedge clk) begin : compare
    logic [15:0] expected;
    if (rst_n && dout_valid) begin
      expected = ref_beat(cur_gain, cur_idx, trans_cnt, cur_wn, model_mem);
      assert ({intensity, phase} == expected)
        else report_mismatch(test_name, 64'(expected), 64'({intensity, phase}));
      trans_cnt = (trans_cnt + 1) % num_trans;
      beat_total = beat_total + 1;
    end
  end

  always @(negedge clk) begin
    if (dut.stm_operator_assert.fail_cnt != 0) begin
      report_failure("A bound protocol assertion failed");
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      report_failure("Timeout: the run did not finish within the cycle limit");
    end
  end

  task automatic wb_access(input logic we, input logic [mem_aw-1:0] adr,
                           input logic [data_w-1:0] dat, output logic [data_w-1:0] rdat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = dat;
    @(negedge clk);
    assert (wb_ack) else report_failure("No Wishbone ack on the cycle after the request");
    rdat = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    @(negedge clk);                          // Idle cycle between transfers.
  endtask

  task automatic check_index(input logic [63:0] st, input logic [31:0] div,
                             input logic [15:0] len);
    logic [63:0] expected;
    sys_time = st;
    freq_div_stm = div;
    cycle_stm = len;
    if (div == '0 || len == '0) begin
      expected = '0;
    end else begin
      expected = (st / 64'(div)) % 64'(len);
    end
    repeat (260) @(negedge clk);
    assert (idx == expected[15:0]) else report_mismatch(test_name, expected, 64'(idx));
  endtask

  task automatic set_index(input logic [15:0] i);
    sys_time = 64'(i);
    freq_div_stm = 32'd1;
    cycle_stm = 16'hffff;
    repeat (260) @(negedge clk);
    assert (idx == i) else report_mismatch("index setup", 64'(i), 64'(idx));
    cur_idx = i;
  endtask

  task automatic run_burst(input string name, input logic gain, input logic [7:0] wn,
                           input logic twice);
    int target;
    test_name = name;
    cur_gain = gain;
    cur_wn = wn;
    gain_mode = gain;
    wavenum = wn;
    target = beat_total + num_trans;
    update = 1'b1;
    @(negedge clk);
    update = 1'b0;
    @(negedge clk);
    if (gain) begin
      assert (!dout_valid) else report_failure("Gain beat came before the two-cycle latency");
    end
    update = twice;                          // Lands while the operator is busy.
    @(negedge clk);
    update = 1'b0;
    if (gain) begin
      assert (dout_valid) else report_failure("No gain beat two cycles after update");
    end
    wait (beat_total == target);
    repeat (30) @(negedge clk);
    assert (beat_total == target)
      else report_mismatch({name, " beat count"}, 64'(target), 64'(beat_total));
  endtask

  initial begin
    logic [data_w-1:0] rdat;
    stm_word_u         w;
    clk = 1'b0;
    rst_n = 1'b0;
    sys_time = '0;
    update = 1'b0;
    cycle_stm = '0;
    freq_div_stm = '0;
    wavenum = '0;
    gain_mode = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    test_name = "reset";
    cur_gain = 1'b1;
    cur_idx = '0;
    cur_wn = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    test_name = "wishbone";
    for (int a = 0; a < mem_words; a++) begin
      w = $random(seed);
      model_mem[a] = w;
      wb_access(1'b1, mem_aw'(a), w, rdat);
    end
    for (int a = 0; a < mem_words; a += 7) begin
      wb_access(1'b0, mem_aw'(a), '0, rdat);
      assert (rdat == model_mem[a]) else report_mismatch(test_name, 64'(model_mem[a]), 64'(rdat));
    end

    test_name = "index";
    check_index(64'd1000, 32'd7, 16'd13);
    check_index(64'h0123_4567_89ab_cdef, 32'h0001_0003, 16'd1000);
    check_index(64'hffff_ffff_ffff_ffff, 32'hffff_ffff, 16'hfffe);
    check_index(64'd5000, 32'd0, 16'd10);
    check_index(64'd5000, 32'd3, 16'd0);

    set_index(16'd5);
    run_burst("gain", 1'b1, 8'd0, 1'b0);
    set_index(16'd37);                       // Base address wraps past the top word.
    run_burst("gain", 1'b1, 8'd0, 1'b0);

    set_index(16'd3);
    run_burst("focus", 1'b0, 8'd1, 1'b0);
    run_burst("focus", 1'b0, 8'd37, 1'b0);
    run_burst("focus", 1'b0, 8'd255, 1'b0);
    set_index(16'd200);
    run_burst("focus", 1'b0, 8'd90, 1'b0);

    run_burst("busy", 1'b1, 8'd0, 1'b1);
    run_burst("busy", 1'b0, 8'd55, 1'b1);

    set_index(16'd0);                        // Word 0 is seen in both views.
    run_burst("mode", 1'b1, 8'd0, 1'b0);
    run_burst("mode", 1'b0, 8'd128, 1'b0);
    run_burst("mode", 1'b1, 8'd0, 1'b0);

    if (dut.stm_operator_assert.fail_cnt == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      report_failure("A bound protocol assertion failed");
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/stm_param_pkg.sv
hw/stm_word_pkg.sv
hw/stm_bus_if.sv
hw/stm_memory.sv
hw/stm_sampler.sv
hw/stm_gain_operator.sv
hw/stm_isqrt.sv
hw/stm_focus_operator.sv
hw/stm_operator.sv
tb/stm_operator_assert.sv
tb/stm_operator_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        ?= stm_operator_tb
RTL_TOP    ?= stm_operator
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)

run: build
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
